//--- adc16_pkg.sv
// adc16 controller shared definitions
`default_nettype none

package adc16_pkg;

  // register words, decoded from address bits 3:2
  typedef enum logic [1:0] {
    REG_3WIRE   = 2'd0,
    REG_CTRL    = 2'd1,
    REG_DELAY_A = 2'd2,
    REG_DELAY_B = 2'd3
  } reg_addr_e;

  // demux mode, as carried in word 1 bits 25:24
  typedef enum logic [1:0] {
    DEMUX_BY1   = 2'b00,
    DEMUX_BY2   = 2'b01,
    DEMUX_BY4   = 2'b10,
    DEMUX_UNDEF = 2'b11
  } demux_mode_e;

  // word 1 field positions
  localparam int DEMUX_WE_BIT = 26;
  localparam int DEMUX_LSB    = 24;
  localparam int RESET_BIT    = 20;
  localparam int SNAP_BIT     = 16;
  localparam int BITSLIP_LSB  = 8;
  localparam int TAP_LSB      = 0;

  // word 0 field positions
  localparam int SCLK_BIT   = 9;
  localparam int SDATA_BIT  = 8;
  localparam int ZDOK_LSB   = 28;
  localparam int LOCKED_LSB = 24;
  localparam int UNITS_LSB  = 20;
  localparam int ROACH2_LSB = 16;

  // decoded word 1 fields, as seen by the pin side
  typedef struct packed {
    demux_mode_e demux;
    logic        chip_reset;
    logic        snap_req;
    logic [7:0]  bitslip;
    logic [4:0]  tap;
  } ctrl_fields_t;

endpackage

`default_nettype wire

//--- adc16_ctrl_if.sv
// adc16 controller internal interfaces
`timescale 1ns/10ps
`default_nettype none

// bus side to register file
interface adc16_reg_if import adc16_pkg::*; ();
  // one-cycle strobes, never both high
  logic        wr_stb;
  logic        rd_stb;
  reg_addr_e   addr;
  logic [31:0] wdata;
  logic [3:0]  sel;
  // combinational read word for the addressed register
  logic [31:0] rdata;

  modport bus  (output wr_stb, rd_stb, addr, wdata, sel, input rdata);
  modport regs (input wr_stb, addr, wdata, sel, output rdata);
endinterface

// register file to pin side, all levels
interface adc16_pin_if import adc16_pkg::*; ();
  logic [15:0]  cfg3wire;
  ctrl_fields_t ctrl;
  logic [63:0]  delay_rst;
  // lock status after synchronization
  logic [1:0]   locked_sync;

  modport regs (output cfg3wire, ctrl, delay_rst, input locked_sync);
  modport pins (input cfg3wire, ctrl, delay_rst, output locked_sync);
endinterface

`default_nettype wire

//--- adc16_wb_slave.sv
// adc16 wishbone slave
`timescale 1ns/10ps
`default_nettype none

module adc16_wb_slave import adc16_pkg::*; (
  input  wire logic        wb_clk_i,
  input  wire logic        wb_rst_i,
  input  wire logic [31:0] wb_adr_i,
  input  wire logic [31:0] wb_dat_i,
  input  wire logic [3:0]  wb_sel_i,
  input  wire logic        wb_we_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  output logic      [31:0] wb_dat_o,
  output logic             wb_ack_o,
  adc16_reg_if.bus         bus
);

  logic        ack_q;
  logic        accept;
  logic [31:0] rdata_q;

  // a pending ack blocks the next acceptance
  // so a held stb is taken every other cycle
  assign accept = wb_stb_i & wb_cyc_i & ~ack_q;

  // all four words are mapped, word select only
  assign bus.addr   = reg_addr_e'(wb_adr_i[3:2]);
  assign bus.wdata  = wb_dat_i;
  assign bus.sel    = wb_sel_i;
  assign bus.wr_stb = accept & wb_we_i;
  assign bus.rd_stb = accept & ~wb_we_i;

  // ack for exactly one cycle after acceptance
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // sample read word in the strobe cycle
  // writes return zero during their ack
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rdata_q <= bus.rd_stb ? bus.rdata : 32'h0;
    end
  end

  assign wb_ack_o = ack_q;
  // data bus idles at zero outside the ack cycle
  assign wb_dat_o = ack_q ? rdata_q : 32'h0;

endmodule

`default_nettype wire

//--- adc16_ctrl_regs.sv
// adc16 control register file
`timescale 1ns/10ps
`default_nettype none

module adc16_ctrl_regs import adc16_pkg::*; #(
  parameter int ROACH2_REV = 2,
  parameter int ZDOK_REV   = 2,
  parameter int NUM_UNITS  = 1
) (
  input  wire logic wb_clk_i,
  input  wire logic wb_rst_i,
  adc16_reg_if.regs bus,
  adc16_pin_if.regs pin
);

  // word 0, only the low half is stored
  logic [15:0] cfg_q;
  // word 1, bit 26 stays zero
  logic [31:0] ctrl_q;
  // words 2 and 3, word 3 in the high half
  logic [63:0] delay_q;
  logic [31:0] status_word;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      // all zero keeps the chip selects inactive
      cfg_q   <= 16'h0;
      ctrl_q  <= 32'h0;
      delay_q <= 64'h0;
    end else if (bus.wr_stb) begin
      unique case (bus.addr)
        REG_3WIRE: begin
          // upper bytes are read-only status
          for (int b = 0; b < 2; b++) begin
            if (bus.sel[b]) cfg_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        REG_CTRL: begin
          for (int b = 0; b < 3; b++) begin
            if (bus.sel[b]) ctrl_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
          // top byte: demux bits only move with W set in the same write
          if (bus.sel[3]) begin
            ctrl_q[31:27] <= bus.wdata[31:27];
            if (bus.wdata[DEMUX_WE_BIT]) begin
              ctrl_q[DEMUX_LSB +: 2] <= bus.wdata[DEMUX_LSB +: 2];
            end
          end
        end
        REG_DELAY_A: begin
          for (int b = 0; b < 4; b++) begin
            if (bus.sel[b]) delay_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        REG_DELAY_B: begin
          for (int b = 0; b < 4; b++) begin
            if (bus.sel[b]) delay_q[32+8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      endcase
    end
  end

  // word 0 readback: compile-time board info plus live lock bits
  always_comb begin
    status_word                    = 32'h0;
    status_word[ZDOK_LSB +: 2]     = 2'(ZDOK_REV);
    status_word[LOCKED_LSB +: 2]   = pin.locked_sync;
    status_word[UNITS_LSB +: 4]    = 4'(NUM_UNITS);
    status_word[ROACH2_LSB +: 2]   = 2'(ROACH2_REV);
    status_word[15:0]              = cfg_q;
  end

  // read mux, sampled by the slave in the strobe cycle
  always_comb begin
    unique case (bus.addr)
      REG_3WIRE:   bus.rdata = status_word;
      REG_CTRL:    bus.rdata = ctrl_q;
      REG_DELAY_A: bus.rdata = delay_q[31:0];
      REG_DELAY_B: bus.rdata = delay_q[63:32];
      default:     bus.rdata = 32'h0;
    endcase
  end

  // field decode toward the pin side
  assign pin.cfg3wire        = cfg_q;
  assign pin.ctrl.demux      = demux_mode_e'(ctrl_q[DEMUX_LSB +: 2]);
  assign pin.ctrl.chip_reset = ctrl_q[RESET_BIT];
  assign pin.ctrl.snap_req   = ctrl_q[SNAP_BIT];
  assign pin.ctrl.bitslip    = ctrl_q[BITSLIP_LSB +: 8];
  assign pin.ctrl.tap        = ctrl_q[TAP_LSB +: 5];
  assign pin.delay_rst       = delay_q;

endmodule

`default_nettype wire

//--- adc16_pin_driver.sv
// adc16 board pin driver
`timescale 1ns/10ps
`default_nettype none

module adc16_pin_driver import adc16_pkg::*; #(
  parameter int NUM_SDATA_LINES = 1,
  parameter int NUM_SCLK_LINES  = 1
) (
  input  wire logic       wb_clk_i,
  input  wire logic       wb_rst_i,
  input  wire logic [1:0] adc16_locked_i,
  adc16_pin_if.pins       pin,
  output logic [3:0]                 adc0_csn_o,
  output logic [3:0]                 adc1_csn_o,
  output logic [NUM_SDATA_LINES-1:0] adc0_sdata_o,
  output logic [NUM_SDATA_LINES-1:0] adc1_sdata_o,
  output logic [NUM_SCLK_LINES-1:0]  adc0_sclk_o,
  output logic [NUM_SCLK_LINES-1:0]  adc1_sclk_o,
  output logic                       adc16_reset_o,
  output logic [7:0]                 adc16_bitslip_o,
  output logic [63:0]                adc16_delay_rst_o,
  output logic [4:0]                 adc16_delay_tap_o,
  output logic                       adc16_snap_req_o,
  output demux_mode_e                adc16_demux_mode_o
);

  // two-flop synchronizer for the board lock inputs
  logic [1:0] locked_meta;
  logic [1:0] locked_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      locked_meta <= 2'b00;
      locked_q    <= 2'b00;
    end else begin
      locked_meta <= adc16_locked_i;
      locked_q    <= locked_meta;
    end
  end

  assign pin.locked_sync = locked_q;

  // one register stage from the register file to every pin
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      // chip selects idle high, everything else low
      adc0_csn_o         <= 4'hf;
      adc1_csn_o         <= 4'hf;
      adc0_sdata_o       <= '0;
      adc1_sdata_o       <= '0;
      adc0_sclk_o        <= '0;
      adc1_sclk_o        <= '0;
      adc16_reset_o      <= 1'b0;
      adc16_bitslip_o    <= 8'h0;
      adc16_delay_rst_o  <= 64'h0;
      adc16_delay_tap_o  <= 5'h0;
      adc16_snap_req_o   <= 1'b0;
      adc16_demux_mode_o <= DEMUX_BY1;
    end else begin
      // stored selects are active high, pins active low
      adc0_csn_o         <= ~pin.cfg3wire[3:0];
      adc1_csn_o         <= ~pin.cfg3wire[7:4];
      // same serial lines on both boards, fanned out per line count
      adc0_sdata_o       <= {NUM_SDATA_LINES{pin.cfg3wire[SDATA_BIT]}};
      adc1_sdata_o       <= {NUM_SDATA_LINES{pin.cfg3wire[SDATA_BIT]}};
      adc0_sclk_o        <= {NUM_SCLK_LINES{pin.cfg3wire[SCLK_BIT]}};
      adc1_sclk_o        <= {NUM_SCLK_LINES{pin.cfg3wire[SCLK_BIT]}};
      adc16_reset_o      <= pin.ctrl.chip_reset;
      adc16_bitslip_o    <= pin.ctrl.bitslip;
      adc16_delay_rst_o  <= pin.delay_rst;
      adc16_delay_tap_o  <= pin.ctrl.tap;
      adc16_snap_req_o   <= pin.ctrl.snap_req;
      adc16_demux_mode_o <= pin.ctrl.demux;
    end
  end

endmodule

`default_nettype wire

//--- adc16_controller_top.sv
// adc16 controller top level
`timescale 1ns/10ps
`default_nettype none

module adc16_controller_top #(
  parameter int ROACH2_REV      = 2,
  parameter int ZDOK_REV        = 2,
  parameter int NUM_UNITS       = 1,
  parameter int NUM_SDATA_LINES = 1,
  parameter int NUM_SCLK_LINES  = 1
) (
  input  wire logic        wb_clk_i,
  input  wire logic        wb_rst_i,
  input  wire logic [31:0] wb_adr_i,
  input  wire logic [31:0] wb_dat_i,
  input  wire logic [3:0]  wb_sel_i,
  input  wire logic        wb_we_i,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  output logic      [31:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_err_o,
  input  wire logic [1:0]  adc16_locked_i,
  output logic [3:0]                 adc0_csn_o,
  output logic [3:0]                 adc1_csn_o,
  output logic [NUM_SDATA_LINES-1:0] adc0_sdata_o,
  output logic [NUM_SDATA_LINES-1:0] adc1_sdata_o,
  output logic [NUM_SCLK_LINES-1:0]  adc0_sclk_o,
  output logic [NUM_SCLK_LINES-1:0]  adc1_sclk_o,
  output logic                       adc16_reset_o,
  output logic [7:0]                 adc16_bitslip_o,
  output logic [63:0]                adc16_delay_rst_o,
  output logic [4:0]                 adc16_delay_tap_o,
  output logic                       adc16_snap_req_o,
  output logic [1:0]                 adc16_demux_mode_o
);

  adc16_reg_if reg_if ();
  adc16_pin_if pin_if ();

  // every word is mapped, so no error responses
  assign wb_err_o = 1'b0;

  adc16_wb_slave adc16_wb_slave_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .bus      (reg_if.bus)
  );

  // board revision info lives in the register file
  adc16_ctrl_regs #(
    .ROACH2_REV (ROACH2_REV),
    .ZDOK_REV   (ZDOK_REV),
    .NUM_UNITS  (NUM_UNITS)
  ) adc16_ctrl_regs_inst (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus      (reg_if.regs),
    .pin      (pin_if.regs)
  );

  // line counts only shape the pin fan-out
  adc16_pin_driver #(
    .NUM_SDATA_LINES (NUM_SDATA_LINES),
    .NUM_SCLK_LINES  (NUM_SCLK_LINES)
  ) adc16_pin_driver_inst (
    .wb_clk_i           (wb_clk_i),
    .wb_rst_i           (wb_rst_i),
    .adc16_locked_i     (adc16_locked_i),
    .pin                (pin_if.pins),
    .adc0_csn_o         (adc0_csn_o),
    .adc1_csn_o         (adc1_csn_o),
    .adc0_sdata_o       (adc0_sdata_o),
    .adc1_sdata_o       (adc1_sdata_o),
    .adc0_sclk_o        (adc0_sclk_o),
    .adc1_sclk_o        (adc1_sclk_o),
    .adc16_reset_o      (adc16_reset_o),
    .adc16_bitslip_o    (adc16_bitslip_o),
    .adc16_delay_rst_o  (adc16_delay_rst_o),
    .adc16_delay_tap_o  (adc16_delay_tap_o),
    .adc16_snap_req_o   (adc16_snap_req_o),
    .adc16_demux_mode_o (adc16_demux_mode_o)
  );

endmodule

`default_nettype wire

//--- adc16_assertions.sv
// wishbone slave protocol checks
`timescale 1ns/10ps
`default_nettype none

module adc16_wb_assertions (
  input wire logic        wb_clk_i,
  input wire logic        wb_rst_i,
  input wire logic        stb_i,
  input wire logic        cyc_i,
  input wire logic        ack_i,
  input wire logic [31:0] dat_i,
  input wire logic        wr_stb_i,
  input wire logic        rd_stb_i
);

  int   violations = 0;
  logic accepted;

  // same acceptance rule as the bus, seen from outside
  assign accepted = stb_i & cyc_i & ~ack_i;

  a_ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else begin
      $error("ack held for two cycles");
      violations++;
    end

  a_ack_after_accept: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    accepted |=> ack_i)
    else begin
      $error("accepted cycle not acknowledged");
      violations++;
    end

  // no ack without a cycle before it
  a_ack_has_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |-> $past(accepted))
    else begin
      $error("ack without an accepted cycle");
      violations++;
    end

  a_strobes_exclusive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wr_stb_i && rd_stb_i))
    else begin
      $error("read and write strobes overlap");
      violations++;
    end

  a_data_idle_zero: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !ack_i |-> (dat_i == 32'h0))
    else begin
      $error("read data nonzero outside ack");
      violations++;
    end

endmodule

bind adc16_wb_slave adc16_wb_assertions adc16_wb_assertions_inst (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .stb_i    (wb_stb_i),
  .cyc_i    (wb_cyc_i),
  .ack_i    (wb_ack_o),
  .dat_i    (wb_dat_o),
  .wr_stb_i (bus.wr_stb),
  .rd_stb_i (bus.rd_stb)
);

`default_nettype wire

//--- tb_adc16_controller.sv
// adc16 controller testbench
`timescale 1ns/10ps
`default_nettype none

module tb_adc16_controller import adc16_pkg::*; ();

  localparam int NUM_UNITS    = 4;
  localparam int NUM_SDATA    = 2;
  localparam int NUM_SCLK     = 1;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 28;
  localparam int CYCLE_LIMIT  = 40 * NUM_TESTS + RESET_CYCLES;
  // cycles a single access may wait for its ack
  localparam int ACK_WAIT     = 8;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_READ_RANDLOCK} op_e;

  // one row of stimulus and expected readback
  typedef struct packed {
    op_e         op;
    reg_addr_e   addr;
    logic [3:0]  sel;
    logic [31:0] wdata;
    logic [1:0]  lock;
    logic [31:0] exp_data;
  } test_t;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic        wb_we_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic [1:0]  adc16_locked_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic [3:0]  adc0_csn_o;
  logic [3:0]  adc1_csn_o;
  logic [NUM_SDATA-1:0] adc0_sdata_o;
  logic [NUM_SDATA-1:0] adc1_sdata_o;
  logic [NUM_SCLK-1:0]  adc0_sclk_o;
  logic [NUM_SCLK-1:0]  adc1_sclk_o;
  logic        adc16_reset_o;
  logic [7:0]  adc16_bitslip_o;
  logic [63:0] adc16_delay_rst_o;
  logic [4:0]  adc16_delay_tap_o;
  logic        adc16_snap_req_o;
  logic [1:0]  adc16_demux_mode_o;

  test_t tests [NUM_TESTS];
  int    errors = 0;
  int    failed_tests = 0;
  int    cycle_count = 0;

  adc16_controller_top #(
    .NUM_UNITS       (NUM_UNITS),
    .NUM_SDATA_LINES (NUM_SDATA),
    .NUM_SCLK_LINES  (NUM_SCLK)
  ) adc16_controller_top_inst (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i), .wb_we_i (wb_we_i),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o), .adc16_locked_i (adc16_locked_i),
    .adc0_csn_o (adc0_csn_o), .adc1_csn_o (adc1_csn_o),
    .adc0_sdata_o (adc0_sdata_o), .adc1_sdata_o (adc1_sdata_o),
    .adc0_sclk_o (adc0_sclk_o), .adc1_sclk_o (adc1_sclk_o),
    .adc16_reset_o (adc16_reset_o), .adc16_bitslip_o (adc16_bitslip_o),
    .adc16_delay_rst_o (adc16_delay_rst_o), .adc16_delay_tap_o (adc16_delay_tap_o),
    .adc16_snap_req_o (adc16_snap_req_o), .adc16_demux_mode_o (adc16_demux_mode_o)
  );

  // 20 ns clock
  always #10 wb_clk_i = ~wb_clk_i;

  // run limit from the table length
  always @(posedge wb_clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, table did not complete", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_demux(input string name, input demux_mode_e got, input demux_mode_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%01h (%s) expected 0x%01h (%s)",
               name, got, got.name(), exp, exp.name());
      errors++;
    end
  endtask

  task automatic check_pins(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%01h expected 0x%01h", name, got, exp);
      errors++;
    end
  endtask

  // one wishbone cycle, held until ack, then exactly one ack expected
  task automatic bus_access(input logic we, input reg_addr_e addr, input logic [3:0] sel,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata  = 32'h0;
    @(posedge wb_clk_i);
    #2;
    wb_adr_i = {28'h0, addr, 2'b00};
    wb_dat_i = wdata;
    wb_sel_i = sel;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < ACK_WAIT) begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("no acknowledge for access to %s within %0d cycles", addr.name(), ACK_WAIT);
      errors++;
    end else begin
      rdata = wb_dat_o;
    end
    @(posedge wb_clk_i);
    #2;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = 4'h0;
    wb_dat_i = 32'h0;
    @(negedge wb_clk_i);
    if (wb_ack_o) begin
      $display("second acknowledge seen for one access to %s", addr.name());
      errors++;
    end
    check_word("wb_err_o", 32'(wb_err_o), 32'h0);
  endtask

  task automatic write_word(input reg_addr_e addr, input logic [3:0] sel,
                            input logic [31:0] data);
    logic [31:0] unused_rdata;
    bus_access(1'b1, addr, sel, data, unused_rdata);
  endtask

  task automatic read_word(input reg_addr_e addr, output logic [31:0] data);
    bus_access(1'b0, addr, 4'hf, 32'h0, data);
  endtask

  // lock input held 3 cycles, longer than the 2-flop sync
  task automatic apply_lock(input logic [1:0] lock);
    @(posedge wb_clk_i);
    #2;
    adc16_locked_i = lock;
    repeat (3) @(posedge wb_clk_i);
  endtask

  // pins that mirror the word just read back
  task automatic check_outputs_for_word(input reg_addr_e addr, input logic [31:0] exp);
    case (addr)
      REG_3WIRE: begin
        // stored selects are active high, pins active low
        check_pins("adc0_csn_o", adc0_csn_o, ~exp[3:0]);
        check_pins("adc1_csn_o", adc1_csn_o, ~exp[7:4]);
        check_pins("adc0_sdata_o", 4'(adc0_sdata_o), 4'({NUM_SDATA{exp[SDATA_BIT]}}));
        check_pins("adc1_sdata_o", 4'(adc1_sdata_o), 4'({NUM_SDATA{exp[SDATA_BIT]}}));
        check_pins("adc0_sclk_o", 4'(adc0_sclk_o), 4'({NUM_SCLK{exp[SCLK_BIT]}}));
        check_pins("adc1_sclk_o", 4'(adc1_sclk_o), 4'({NUM_SCLK{exp[SCLK_BIT]}}));
      end
      REG_CTRL: begin
        check_demux("adc16_demux_mode_o", demux_mode_e'(adc16_demux_mode_o),
                    demux_mode_e'(exp[DEMUX_LSB +: 2]));
        check_word("adc16_reset_o", 32'(adc16_reset_o), 32'(exp[RESET_BIT]));
        check_word("adc16_snap_req_o", 32'(adc16_snap_req_o), 32'(exp[SNAP_BIT]));
        check_word("adc16_bitslip_o", 32'(adc16_bitslip_o), 32'(exp[BITSLIP_LSB +: 8]));
        check_word("adc16_delay_tap_o", 32'(adc16_delay_tap_o), 32'(exp[TAP_LSB +: 5]));
      end
      REG_DELAY_A: check_word("adc16_delay_rst_o[31:0]", adc16_delay_rst_o[31:0], exp);
      REG_DELAY_B: check_word("adc16_delay_rst_o[63:32]", adc16_delay_rst_o[63:32], exp);
      default: ;
    endcase
  endtask

  // idle state right after reset
  task automatic check_reset_state();
    @(negedge wb_clk_i);
    check_pins("adc0_csn_o", adc0_csn_o, 4'hf);
    check_pins("adc1_csn_o", adc1_csn_o, 4'hf);
    check_pins("adc0_sdata_o", 4'(adc0_sdata_o), 4'h0);
    check_pins("adc1_sdata_o", 4'(adc1_sdata_o), 4'h0);
    check_pins("adc0_sclk_o", 4'(adc0_sclk_o), 4'h0);
    check_pins("adc1_sclk_o", 4'(adc1_sclk_o), 4'h0);
    check_demux("adc16_demux_mode_o", demux_mode_e'(adc16_demux_mode_o), DEMUX_BY1);
    check_word("adc16_reset_o", 32'(adc16_reset_o), 32'h0);
    check_word("adc16_snap_req_o", 32'(adc16_snap_req_o), 32'h0);
    check_word("adc16_bitslip_o", 32'(adc16_bitslip_o), 32'h0);
    check_word("adc16_delay_tap_o", 32'(adc16_delay_tap_o), 32'h0);
    check_word("adc16_delay_rst_o[31:0]", adc16_delay_rst_o[31:0], 32'h0);
    check_word("adc16_delay_rst_o[63:32]", adc16_delay_rst_o[63:32], 32'h0);
    check_word("wb_ack_o", 32'(wb_ack_o), 32'h0);
    check_word("wb_dat_o", wb_dat_o, 32'h0);
    check_word("wb_err_o", 32'(wb_err_o), 32'h0);
  endtask

  // word 0 upper half is ZDOK_REV 2, lock, NUM_UNITS 4, ROACH2_REV 2
  task automatic load_tests();
    tests[0]  = '{OP_WRITE, REG_3WIRE, 4'hf, 32'h0000_0355, 2'b00, 32'h0};
    tests[1]  = '{OP_READ, REG_3WIRE, 4'hf, 32'h0, 2'b01, 32'h2142_0355};
    // upper bytes of word 0 are status, not stored
    tests[2]  = '{OP_WRITE, REG_3WIRE, 4'h1, 32'hffff_ff0f, 2'b00, 32'h0};
    tests[3]  = '{OP_READ, REG_3WIRE, 4'hf, 32'h0, 2'b10, 32'h2242_030f};
    tests[4]  = '{OP_WRITE, REG_3WIRE, 4'h2, 32'h0000_0100, 2'b00, 32'h0};
    tests[5]  = '{OP_READ, REG_3WIRE, 4'hf, 32'h0, 2'b11, 32'h2342_010f};
    // demux field held, W clear
    tests[6]  = '{OP_WRITE, REG_CTRL, 4'hf, 32'h0211_a51f, 2'b00, 32'h0};
    tests[7]  = '{OP_READ, REG_CTRL, 4'hf, 32'h0, 2'b00, 32'h0011_a51f};
    tests[8]  = '{OP_WRITE, REG_CTRL, 4'h8, 32'h0600_0000, 2'b00, 32'h0};
    tests[9]  = '{OP_READ, REG_CTRL, 4'hf, 32'h0, 2'b00, 32'h0211_a51f};
    // bits 31:27 always written, demux untouched
    tests[10] = '{OP_WRITE, REG_CTRL, 4'h8, 32'hf900_0000, 2'b00, 32'h0};
    tests[11] = '{OP_READ, REG_CTRL, 4'hf, 32'h0, 2'b00, 32'hfa11_a51f};
    tests[12] = '{OP_WRITE, REG_CTRL, 4'h9, 32'h0700_0003, 2'b00, 32'h0};
    tests[13] = '{OP_READ, REG_CTRL, 4'hf, 32'h0, 2'b00, 32'h0311_a503};
    tests[14] = '{OP_WRITE, REG_CTRL, 4'h6, 32'h00ee_5a00, 2'b00, 32'h0};
    tests[15] = '{OP_READ, REG_CTRL, 4'hf, 32'h0, 2'b00, 32'h03ee_5a03};
    tests[16] = '{OP_WRITE, REG_DELAY_A, 4'hf, 32'h1234_5678, 2'b00, 32'h0};
    tests[17] = '{OP_WRITE, REG_DELAY_B, 4'hf, 32'h9abc_def0, 2'b00, 32'h0};
    tests[18] = '{OP_READ, REG_DELAY_A, 4'hf, 32'h0, 2'b00, 32'h1234_5678};
    tests[19] = '{OP_READ, REG_DELAY_B, 4'hf, 32'h0, 2'b00, 32'h9abc_def0};
    tests[20] = '{OP_WRITE, REG_DELAY_A, 4'h5, 32'haaaa_bbbb, 2'b00, 32'h0};
    tests[21] = '{OP_WRITE, REG_DELAY_B, 4'ha, 32'h1111_2222, 2'b00, 32'h0};
    tests[22] = '{OP_READ, REG_DELAY_A, 4'hf, 32'h0, 2'b00, 32'h12aa_56bb};
    tests[23] = '{OP_READ, REG_DELAY_B, 4'hf, 32'h0, 2'b00, 32'h11bc_22f0};
    // lock bits replaced by the random value at run time
    tests[24] = '{OP_READ_RANDLOCK, REG_3WIRE, 4'hf, 32'h0, 2'b00, 32'h2042_010f};
    tests[25] = '{OP_READ_RANDLOCK, REG_3WIRE, 4'hf, 32'h0, 2'b00, 32'h2042_010f};
    tests[26] = '{OP_READ_RANDLOCK, REG_3WIRE, 4'hf, 32'h0, 2'b00, 32'h2042_010f};
    tests[27] = '{OP_READ, REG_CTRL, 4'hf, 32'h0, 2'b00, 32'h03ee_5a03};
  endtask

  initial begin
    test_t       t;
    logic [1:0]  lock;
    logic [31:0] exp;
    logic [31:0] got;
    int          errors_before;
    int          assert_fails;
    void'($urandom(32'ha4ff_1a95));
    wb_clk_i       = 1'b0;
    wb_rst_i       = 1'b1;
    wb_adr_i       = 32'h0;
    wb_dat_i       = 32'h0;
    wb_sel_i       = 4'h0;
    wb_we_i        = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    adc16_locked_i = 2'b00;
    load_tests();
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;
    check_reset_state();
    $display("test reset_state: %s", (errors == 0) ? "ok" : "failed");
    if (errors != 0) failed_tests++;
    for (int i = 0; i < NUM_TESTS; i++) begin
      t             = tests[i];
      errors_before = errors;
      lock          = t.lock;
      exp           = t.exp_data;
      if (t.op == OP_READ_RANDLOCK) begin
        lock                 = 2'($urandom);
        exp[LOCKED_LSB +: 2] = lock;
      end
      apply_lock(lock);
      if (t.op == OP_WRITE) begin
        write_word(t.addr, t.sel, t.wdata);
      end else begin
        read_word(t.addr, got);
        check_word("wb_dat_o", got, exp);
        check_outputs_for_word(t.addr, exp);
      end
      if (errors != errors_before) failed_tests++;
      $display("test %0d %s %s: %s", i, t.op.name(), t.addr.name(),
               (errors == errors_before) ? "ok" : "failed");
    end
    assert_fails =
      adc16_controller_top_inst.adc16_wb_slave_inst.adc16_wb_assertions_inst.violations;
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             NUM_TESTS + 1, failed_tests, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
adc16_pkg.sv
adc16_ctrl_if.sv
adc16_wb_slave.sv
adc16_ctrl_regs.sv
adc16_pin_driver.sv
adc16_controller_top.sv
adc16_assertions.sv
tb_adc16_controller.sv

//--- Makefile
# Verilator build and run for the adc16 controller testbench

VERILATOR ?= verilator
TOP       ?= tb_adc16_controller
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
